//--- mipsPkg.sv
`default_nettype none

package mipsPkg;

    localparam int WORD_W      = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int NUM_REGS    = 32;
    localparam int IMEM_ADDR_W = 6;
    localparam int DMEM_ADDR_W = 6;
    localparam int IMEM_DEPTH  = 64;
    localparam int DMEM_DEPTH  = 64;

    // Primary opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    // R-type funct codes
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    typedef logic [WORD_W-1:0]      word_t;
    typedef logic [REG_ADDR_W-1:0]  regAddr_t;
    typedef logic [IMEM_ADDR_W-1:0] imemAddr_t;
    typedef logic [DMEM_ADDR_W-1:0] dmemAddr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI
    } aluOp_t;

    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,
        FWD_WB
    } fwdSel_t;

    typedef struct packed {
        logic   regWrite;
        logic   memToReg;
        logic   memWrite;
        aluOp_t aluOp;
        logic   aluSrcImm;
        logic   regDst;
        logic   zeroExt;
        logic   branch;
        logic   jump;
    } decodeCtrl_t;

    typedef struct packed {
        logic  valid;
        word_t instr;
        word_t pcPlus4;
    } ifId_t;

    typedef struct packed {
        logic     valid;
        logic     regWrite;
        logic     memToReg;
        logic     memWrite;
        aluOp_t   aluOp;
        logic     aluSrcImm;
        regAddr_t rs;
        regAddr_t rt;
        regAddr_t dest;
        word_t    opA;
        word_t    opB;
        word_t    imm;
    } idEx_t;

    typedef struct packed {
        logic     valid;
        logic     regWrite;
        logic     memToReg;
        logic     memWrite;
        regAddr_t dest;
        word_t    aluRes;
        word_t    storeData;
    } exMem_t;

    typedef struct packed {
        logic     valid;
        logic     regWrite;
        regAddr_t dest;
        word_t    result;
    } memWb_t;

endpackage

`default_nettype wire

//--- fetchUnit.sv
`timescale 1ns/1ps
`default_nettype none

module fetchUnit
    import mipsPkg::*;
(
    input  logic      clk,
    input  logic      arstN,
    input  logic      run,
    input  logic      imemWe,
    input  imemAddr_t imemAddr,
    input  word_t     imemData,
    input  logic      stall,
    input  logic      taken,
    input  logic      jump,
    input  word_t     branchTarget,
    input  word_t     jumpTarget,
    output word_t     instr,
    output word_t     pcPlus4
);

    word_t     imem [IMEM_DEPTH];
    word_t     pc;
    imemAddr_t fetchIdx;

    assign fetchIdx = pc[IMEM_ADDR_W+1:2];
    assign pcPlus4  = pc + word_t'(4);

    // All-zero word decodes as a no-op
    assign instr = run ? imem[fetchIdx] : '0;

    // Loader only while the core is halted
    always_ff @(posedge clk) begin
        if (imemWe && !run) begin
            imem[imemAddr] <= imemData;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (!run) begin
            pc <= '0;
        end else if (!stall) begin
            if (jump) begin
                pc <= jumpTarget;
            end else if (taken) begin
                pc <= branchTarget;
            end else begin
                pc <= pcPlus4;
            end
        end
    end

endmodule

`default_nettype wire

//--- controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit
    import mipsPkg::*;
(
    input  word_t       instr,
    output decodeCtrl_t ctrl
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        ctrl = '0;
        case (opcode)
            OP_RTYPE: begin
                ctrl.regDst = 1'b1;
                ctrl.regWrite = 1'b1;
                case (funct)
                    FN_ADDU: ctrl.aluOp = ALU_ADD;
                    FN_SUBU: ctrl.aluOp = ALU_SUB;
                    FN_AND:  ctrl.aluOp = ALU_AND;
                    FN_OR:   ctrl.aluOp = ALU_OR;
                    FN_SLT:  ctrl.aluOp = ALU_SLT;
                    // Includes sll $0,$0,0
                    default: ctrl = '0;
                endcase
            end
            OP_ORI: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.zeroExt   = 1'b1;
                ctrl.aluOp     = ALU_OR;
            end
            OP_LUI: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.zeroExt   = 1'b1;
                ctrl.aluOp     = ALU_LUI;
            end
            OP_LW: begin
                ctrl.regWrite  = 1'b1;
                ctrl.memToReg  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            OP_SW: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            OP_BEQ: begin
                ctrl.branch = 1'b1;
            end
            OP_J: begin
                ctrl.jump = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile
    import mipsPkg::*;
(
    input  logic     clk,
    input  logic     arstN,
    input  logic     we,
    input  regAddr_t wAddr,
    input  word_t    wData,
    input  regAddr_t rAddrA,
    input  regAddr_t rAddrB,
    output word_t    rDataA,
    output word_t    rDataB
);

    word_t regs [NUM_REGS];
    logic  wrLive;

    // $0 is never written so it reads back zero
    assign wrLive = we && (wAddr != '0);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrLive) begin
            regs[wAddr] <= wData;
        end
    end

    // Write-first bypass for same-cycle read
    assign rDataA = (wrLive && wAddr == rAddrA) ? wData : regs[rAddrA];
    assign rDataB = (wrLive && wAddr == rAddrB) ? wData : regs[rAddrB];

endmodule

`default_nettype wire

//--- hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit
    import mipsPkg::*;
(
    input  regAddr_t rsD,
    input  regAddr_t rtD,
    input  logic     branchD,
    input  regAddr_t rsE,
    input  regAddr_t rtE,
    input  regAddr_t destE,
    input  logic     regWriteE,
    input  logic     memToRegE,
    input  regAddr_t destM,
    input  logic     regWriteM,
    input  logic     memToRegM,
    input  regAddr_t destW,
    input  logic     regWriteW,
    output fwdSel_t  fwdAE,
    output fwdSel_t  fwdBE,
    output logic     fwdAD,
    output logic     fwdBD,
    output logic     stall
);

    logic loadUse;
    logic branchWait;

    function automatic logic hit(regAddr_t dest, logic we, regAddr_t src);
        return we && (dest != '0) && (dest == src);
    endfunction

    function automatic fwdSel_t exSel(regAddr_t src);
        if (hit(destM, regWriteM, src)) begin
            return FWD_MEM;
        end else if (hit(destW, regWriteW, src)) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    assign fwdAE = exSel(rsE);
    assign fwdBE = exSel(rtE);

    // Decode compare only takes ALU results from MEM
    assign fwdAD = hit(destM, regWriteM && !memToRegM, rsD);
    assign fwdBD = hit(destM, regWriteM && !memToRegM, rtD);

    assign loadUse = hit(destE, memToRegE, rsD) || hit(destE, memToRegE, rtD);

    assign branchWait = branchD && (hit(destE, regWriteE, rsD) || hit(destE, regWriteE, rtD)
                                 || hit(destM, memToRegM, rsD) || hit(destM, memToRegM, rtD));

    assign stall = loadUse || branchWait;

endmodule

`default_nettype wire

//--- dataMem.sv
`timescale 1ns/1ps
`default_nettype none

module dataMem
    import mipsPkg::*;
(
    input  logic      clk,
    input  logic      we,
    input  dmemAddr_t addr,
    input  word_t     wData,
    output word_t     rData
);

    word_t mem [DMEM_DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wData;
        end
    end

    // Combinational read
    assign rData = mem[addr];

endmodule

`default_nettype wire

//--- mipsCore.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCore
    import mipsPkg::*;
(
    input  logic      clk,
    input  logic      arstN,
    input  logic      run,
    input  logic      imemWe,
    input  imemAddr_t imemAddr,
    input  word_t     imemData,
    output logic      wbValid,
    output regAddr_t  wbReg,
    output word_t     wbData
);

    ifId_t       ifId;
    idEx_t       idEx, idExNext;
    exMem_t      exMem;
    memWb_t      memWb;

    word_t       instrF, pcPlus4F;
    decodeCtrl_t ctrl;
    regAddr_t    rsD, rtD, rdD, srcA, srcB;
    word_t       rDataA, rDataB, cmpA, cmpB, immExt;
    word_t       branchTarget, jumpTarget;
    logic        taken, stall, fwdAD, fwdBD, useRs, useRt;
    fwdSel_t     fwdAE, fwdBE;
    word_t       fwdA, fwdB, aluB, aluRes, memRData;
    logic        rfWe;

    function automatic word_t fwdMux(fwdSel_t sel, word_t regVal, word_t memVal, word_t wbVal);
        case (sel)
            FWD_MEM: return memVal;
            FWD_WB:  return wbVal;
            default: return regVal;
        endcase
    endfunction

    fetchUnit fetchUnit_inst (
        .clk(clk), .arstN(arstN), .run(run),
        .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
        .stall(stall), .taken(taken), .jump(ctrl.jump),
        .branchTarget(branchTarget), .jumpTarget(jumpTarget),
        .instr(instrF), .pcPlus4(pcPlus4F)
    );

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ifId <= '0;
        end else if (!stall) begin
            ifId <= '{valid: run, instr: instrF, pcPlus4: pcPlus4F};
        end
    end

    // Decode
    assign rsD = ifId.instr[25:21];
    assign rtD = ifId.instr[20:16];
    assign rdD = ifId.instr[15:11];

    controlUnit controlUnit_inst (.instr(ifId.instr), .ctrl(ctrl));

    regFile regFile_inst (
        .clk(clk), .arstN(arstN),
        .we(rfWe), .wAddr(memWb.dest), .wData(memWb.result),
        .rAddrA(rsD), .rAddrB(rtD), .rDataA(rDataA), .rDataB(rDataB)
    );

    // Fields that are not source registers must not raise hazards
    assign useRs = ctrl.memWrite || ctrl.branch || (ctrl.regWrite && ctrl.aluOp != ALU_LUI);
    assign useRt = ctrl.regDst || ctrl.memWrite || ctrl.branch;
    assign srcA  = useRs ? rsD : '0;
    assign srcB  = useRt ? rtD : '0;

    assign cmpA  = fwdAD ? exMem.aluRes : rDataA;
    assign cmpB  = fwdBD ? exMem.aluRes : rDataB;
    assign taken = ctrl.branch && (cmpA == cmpB);

    assign immExt = ctrl.zeroExt ? {16'b0, ifId.instr[15:0]}
                                 : {{16{ifId.instr[15]}}, ifId.instr[15:0]};
    assign branchTarget = ifId.pcPlus4 + {immExt[29:0], 2'b00};
    assign jumpTarget   = {ifId.pcPlus4[31:28], ifId.instr[25:0], 2'b00};

    hazardUnit hazardUnit_inst (
        .rsD(srcA), .rtD(srcB), .branchD(ctrl.branch),
        .rsE(idEx.rs), .rtE(idEx.rt), .destE(idEx.dest),
        .regWriteE(idEx.regWrite), .memToRegE(idEx.memToReg),
        .destM(exMem.dest), .regWriteM(exMem.regWrite), .memToRegM(exMem.memToReg),
        .destW(memWb.dest), .regWriteW(rfWe),
        .fwdAE(fwdAE), .fwdBE(fwdBE), .fwdAD(fwdAD), .fwdBD(fwdBD), .stall(stall)
    );

    always_comb begin
        idExNext.valid     = ifId.valid;
        idExNext.regWrite  = ctrl.regWrite;
        idExNext.memToReg  = ctrl.memToReg;
        idExNext.memWrite  = ctrl.memWrite;
        idExNext.aluOp     = ctrl.aluOp;
        idExNext.aluSrcImm = ctrl.aluSrcImm;
        idExNext.rs        = srcA;
        idExNext.rt        = srcB;
        idExNext.dest      = ctrl.regDst ? rdD : rtD;
        idExNext.opA       = cmpA;
        idExNext.opB       = cmpB;
        idExNext.imm       = immExt;
    end

    // Stall injects a bubble behind the held decode
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            idEx <= '0;
        end else if (stall) begin
            idEx <= '0;
        end else begin
            idEx <= idExNext;
        end
    end

    // Execute
    assign fwdA = fwdMux(fwdAE, idEx.opA, exMem.aluRes, memWb.result);
    assign fwdB = fwdMux(fwdBE, idEx.opB, exMem.aluRes, memWb.result);
    assign aluB = idEx.aluSrcImm ? idEx.imm : fwdB;

    always_comb begin
        case (idEx.aluOp)
            ALU_ADD: aluRes = fwdA + aluB;
            ALU_SUB: aluRes = fwdA - aluB;
            ALU_AND: aluRes = fwdA & aluB;
            ALU_OR:  aluRes = fwdA | aluB;
            ALU_SLT: aluRes = word_t'($signed(fwdA) < $signed(aluB));
            ALU_LUI: aluRes = {aluB[15:0], 16'b0};
            default: aluRes = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exMem <= '0;
        end else begin
            exMem <= '{valid: idEx.valid, regWrite: idEx.regWrite,
                       memToReg: idEx.memToReg, memWrite: idEx.memWrite,
                       dest: idEx.dest, aluRes: aluRes, storeData: fwdB};
        end
    end

    // Byte address to word index
    dataMem dataMem_inst (
        .clk(clk), .we(exMem.valid && exMem.memWrite),
        .addr(exMem.aluRes[DMEM_ADDR_W+1:2]),
        .wData(exMem.storeData), .rData(memRData)
    );

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            memWb <= '0;
        end else begin
            memWb <= '{valid: exMem.valid, regWrite: exMem.regWrite, dest: exMem.dest,
                       result: exMem.memToReg ? memRData : exMem.aluRes};
        end
    end

    // Write-back
    assign rfWe    = memWb.valid && memWb.regWrite;
    assign wbValid = rfWe && (memWb.dest != '0);
    assign wbReg   = memWb.dest;
    assign wbData  = memWb.result;

endmodule

`default_nettype wire

//--- tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock (
    output logic clk
);

    // 20 ns period
    initial begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;

endmodule

`default_nettype wire

//--- mipsCore_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCore_checker
    import mipsPkg::*;
(
    input logic     clk,
    input logic     arstN,
    input logic     run,
    input logic     imemWe,
    input logic     wbValid,
    input regAddr_t wbReg,
    input word_t    wbData
);

    // Writes to $0 never reach the port
    wbRegNonZero: assert property (@(posedge clk) disable iff (!arstN)
        wbValid |-> wbReg != '0)
        else $error("write-back port reports register zero");

    wbDataKnown: assert property (@(posedge clk) disable iff (!arstN)
        wbValid |-> !$isunknown(wbData))
        else $error("write-back data is unknown while wbValid is high");

    // Loader is only used while the core is halted
    loadWhileHalted: assert property (@(posedge clk) disable iff (!arstN)
        !(imemWe && run))
        else $error("imemWe is high while run is high");

endmodule

`default_nettype wire

//--- tb_mipsCore.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mipsCore
    import mipsPkg::*;
;

    typedef struct packed {
        regAddr_t regNum;
        word_t    data;
    } wbExp_t;

    logic      clk;
    logic      arstN;
    logic      run;
    logic      imemWe;
    imemAddr_t imemAddr;
    word_t     imemData;
    logic      wbValid;
    regAddr_t  wbReg;
    word_t     wbData;

    word_t     prog [$];
    wbExp_t    expQ [$];
    word_t     mdlRegs [NUM_REGS];
    word_t     mdlMem [DMEM_DEPTH];
    int        budget = 40;
    string     curTest = "reset";

    tbClock tbClock_inst (.clk(clk));

    mipsCore mipsCore_inst (
        .clk(clk), .arstN(arstN), .run(run),
        .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
        .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
    );

    bind mipsCore mipsCore_checker mipsCore_checker_inst (
        .clk(clk), .arstN(arstN), .run(run), .imemWe(imemWe),
        .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
    );

    task automatic failRun(string line);
        $display("%s", line);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkReg(regAddr_t got, regAddr_t exp, string what);
        if (got !== exp) begin
            failRun($sformatf("mismatch at %0t: %s %s got $%0d, expected $%0d",
                              $time, curTest, what, got, exp));
        end
    endtask

    task automatic checkWord(word_t got, word_t exp, string what);
        if (got !== exp) begin
            failRun($sformatf("mismatch at %0t: %s %s got %08h, expected %08h",
                              $time, curTest, what, got, exp));
        end
    endtask

    // Instruction encoders
    function automatic word_t rType(logic [5:0] fn, regAddr_t rd, regAddr_t rs, regAddr_t rt);
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t iType(logic [5:0] op, regAddr_t rt, regAddr_t rs,
                                    logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t jType(logic [25:0] target);
        return {OP_J, target};
    endfunction

    // ISA-level model with one delay slot that fills expQ in program order
    task automatic modelProgram();
        int         pc;
        int         npc;
        int         nn;
        int         steps;
        word_t      ins;
        word_t      a;
        word_t      b;
        word_t      res;
        word_t      addr;
        word_t      simm;
        logic       wr;
        regAddr_t   dest;
        wbExp_t     entry;
        pc = 0;
        npc = 1;
        steps = 0;
        while (pc < prog.size() && steps < 4 * IMEM_DEPTH) begin
            ins  = prog[pc];
            a    = mdlRegs[ins[25:21]];
            b    = mdlRegs[ins[20:16]];
            simm = {{16{ins[15]}}, ins[15:0]};
            addr = a + simm;
            dest = ins[20:16];
            wr   = 1'b0;
            res  = '0;
            nn   = npc + 1;
            case (ins[31:26])
                OP_RTYPE: begin
                    dest = ins[15:11];
                    wr   = 1'b1;
                    case (ins[5:0])
                        FN_ADDU: res = a + b;
                        FN_SUBU: res = a - b;
                        FN_AND:  res = a & b;
                        FN_OR:   res = a | b;
                        FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: wr = 1'b0;
                    endcase
                end
                OP_ORI: begin
                    wr  = 1'b1;
                    res = a | {16'b0, ins[15:0]};
                end
                OP_LUI: begin
                    wr  = 1'b1;
                    res = {ins[15:0], 16'b0};
                end
                OP_LW: begin
                    wr  = 1'b1;
                    res = mdlMem[dmemAddr_t'(addr >> 2)];
                end
                OP_SW: mdlMem[dmemAddr_t'(addr >> 2)] = b;
                OP_BEQ: begin
                    if (a == b) begin
                        nn = pc + 1 + int'($signed(ins[15:0]));
                    end
                end
                OP_J: nn = int'(ins[25:0]);
                default: wr = 1'b0;
            endcase
            if (wr && dest != '0) begin
                mdlRegs[dest] = res;
                entry.regNum = dest;
                entry.data = res;
                expQ.push_back(entry);
            end
            pc = npc;
            npc = nn;
            steps++;
        end
    endtask

    // Whole memory is rewritten so stale words from earlier programs become no-ops
    task automatic loadProgram();
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            @(negedge clk);
            imemWe = 1'b1;
            imemAddr = imemAddr_t'(i);
            imemData = (i < prog.size()) ? prog[i] : '0;
        end
        @(negedge clk);
        imemWe = 1'b0;
    endtask

    task automatic runProgram(string name);
        wbExp_t exp;
        curTest = name;
        budget += IMEM_DEPTH + 16 + prog.size() * 10;
        loadProgram();
        modelProgram();
        @(negedge clk);
        run = 1'b1;
        while (expQ.size() > 0) begin
            @(negedge clk);
            if (wbValid) begin
                exp = expQ.pop_front();
                checkReg(wbReg, exp.regNum, "wbReg");
                checkWord(wbData, exp.data, "wbData");
            end
        end
        run = 1'b0;
        repeat (8) begin
            @(negedge clk);
            if (wbValid) begin
                failRun($sformatf("%s: unexpected write-back to $%0d after the program ended",
                                  name, wbReg));
            end
        end
    endtask

    task automatic testAluOps();
        word_t x;
        word_t y;
        x = $urandom;
        y = $urandom;
        prog.delete();
        prog.push_back(iType(OP_LUI, 5'd1, 5'd0, x[31:16]));
        prog.push_back(iType(OP_ORI, 5'd1, 5'd1, x[15:0]));
        prog.push_back(iType(OP_LUI, 5'd2, 5'd0, y[31:16]));
        prog.push_back(iType(OP_ORI, 5'd2, 5'd2, y[15:0]));
        prog.push_back(rType(FN_ADDU, 5'd3, 5'd1, 5'd2));
        prog.push_back(rType(FN_SUBU, 5'd4, 5'd1, 5'd2));
        prog.push_back(rType(FN_AND, 5'd5, 5'd1, 5'd2));
        prog.push_back(rType(FN_OR, 5'd6, 5'd1, 5'd2));
        prog.push_back(rType(FN_SLT, 5'd7, 5'd1, 5'd2));
        prog.push_back(rType(FN_SLT, 5'd8, 5'd2, 5'd1));
        runProgram("alu ops");
    endtask

    task automatic testForwarding();
        prog.delete();
        prog.push_back(rType(FN_ADDU, 5'd9, 5'd1, 5'd2));
        prog.push_back(rType(FN_SUBU, 5'd10, 5'd9, 5'd1));
        prog.push_back(rType(FN_OR, 5'd11, 5'd10, 5'd9));
        prog.push_back(rType(FN_AND, 5'd12, 5'd11, 5'd10));
        prog.push_back(rType(FN_ADDU, 5'd13, 5'd12, 5'd12));
        prog.push_back(rType(FN_SLT, 5'd14, 5'd13, 5'd9));
        prog.push_back(rType(FN_ADDU, 5'd15, 5'd14, 5'd13));
        runProgram("forwarding");
    endtask

    task automatic testLoadStore();
        word_t c;
        word_t d;
        c = $urandom;
        d = $urandom;
        prog.delete();
        prog.push_back(iType(OP_ORI, 5'd16, 5'd0, 16'd16));
        prog.push_back(iType(OP_LUI, 5'd17, 5'd0, c[31:16]));
        prog.push_back(iType(OP_ORI, 5'd17, 5'd17, c[15:0]));
        prog.push_back(iType(OP_LUI, 5'd18, 5'd0, d[31:16]));
        prog.push_back(iType(OP_ORI, 5'd18, 5'd18, d[15:0]));
        prog.push_back(iType(OP_SW, 5'd17, 5'd16, 16'd0));
        // Byte 276 wraps onto word 5
        prog.push_back(iType(OP_SW, 5'd18, 5'd16, 16'd260));
        prog.push_back(iType(OP_SW, 5'd3, 5'd16, 16'd8));
        prog.push_back(iType(OP_LW, 5'd19, 5'd16, 16'd4));
        prog.push_back(iType(OP_LW, 5'd20, 5'd16, 16'd0));
        prog.push_back(rType(FN_ADDU, 5'd21, 5'd20, 5'd19));
        prog.push_back(iType(OP_LW, 5'd22, 5'd16, 16'd256));
        prog.push_back(iType(OP_LW, 5'd23, 5'd16, 16'd8));
        runProgram("load/store");
    endtask

    task automatic testBranches();
        prog.delete();
        prog.push_back(iType(OP_ORI, 5'd23, 5'd0, 16'd5));
        prog.push_back(iType(OP_ORI, 5'd24, 5'd23, 16'd0));
        prog.push_back(iType(OP_BEQ, 5'd24, 5'd23, 16'd3));
        prog.push_back(rType(FN_ADDU, 5'd25, 5'd23, 5'd24));
        prog.push_back(iType(OP_ORI, 5'd26, 5'd0, 16'd1));
        prog.push_back(iType(OP_ORI, 5'd26, 5'd0, 16'd2));
        prog.push_back(iType(OP_ORI, 5'd27, 5'd23, 16'd7));
        // Not taken since 7 differs from 5
        prog.push_back(iType(OP_BEQ, 5'd23, 5'd27, 16'd2));
        prog.push_back(iType(OP_ORI, 5'd28, 5'd0, 16'd3));
        prog.push_back(jType(26'd12));
        prog.push_back(iType(OP_ORI, 5'd29, 5'd0, 16'd4));
        prog.push_back(iType(OP_ORI, 5'd30, 5'd0, 16'd9));
        prog.push_back(iType(OP_LW, 5'd31, 5'd16, 16'd0));
        prog.push_back(iType(OP_BEQ, 5'd17, 5'd31, 16'd2));
        prog.push_back(iType(OP_ORI, 5'd26, 5'd0, 16'd6));
        prog.push_back(iType(OP_ORI, 5'd30, 5'd0, 16'd10));
        prog.push_back(rType(FN_ADDU, 5'd26, 5'd26, 5'd31));
        runProgram("branches");
    endtask

    task automatic testZeroReg();
        prog.delete();
        prog.push_back(iType(OP_ORI, 5'd0, 5'd0, 16'h1234));
        prog.push_back(rType(FN_ADDU, 5'd0, 5'd1, 5'd2));
        prog.push_back(iType(OP_LUI, 5'd0, 5'd0, 16'hffff));
        prog.push_back(rType(FN_OR, 5'd1, 5'd0, 5'd0));
        prog.push_back(rType(FN_ADDU, 5'd2, 5'd0, 5'd3));
        prog.push_back(iType(OP_LW, 5'd0, 5'd16, 16'd0));
        prog.push_back(rType(FN_ADDU, 5'd4, 5'd0, 5'd0));
        runProgram("zero register");
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > budget) begin
                failRun($sformatf("timeout in %s: write-backs stopped before the program ended",
                                  curTest));
            end
        end
    end

    initial begin
        arstN = 1'b0;
        run = 1'b0;
        imemWe = 1'b0;
        imemAddr = '0;
        imemData = '0;
        void'($urandom(61854));
        for (int i = 0; i < NUM_REGS; i++) begin
            mdlRegs[i] = '0;
        end
        repeat (3) @(negedge clk);
        arstN = 1'b1;
        testAluOps();
        testForwarding();
        testLoadStore();
        testBranches();
        testZeroReg();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
mipsPkg.sv
fetchUnit.sv
controlUnit.sv
regFile.sv
hazardUnit.sv
dataMem.sv
mipsCore.sv
tbClock.sv
mipsCore_checker.sv
tb_mipsCore.sv

//--- run.sh
#!/bin/sh
# Build and run the MIPS pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_mipsCore \
    -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/simv)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Simulation finished: PASS"; then
    exit 0
fi
echo "pass message not found"
exit 1
